// ==== Makefile ====
# Verilator build and run for the rhythm game core

VERILATOR ?= verilator
TOP       ?= tb_rhythm
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# Exit status comes from the search for the pass message
run: compile
	./$(SIM_BIN) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// ==== chart/chart_fetch.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

module chart_fetch
	import rhythm_pkg::*;
(
	input  logic                    Clk,
	input  logic                    reset,
	chart_if.source                 chart,
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	output logic                    sram_oe_n,
	input  logic [`SRAM_DATA_W-1:0] sram_dq
);

	localparam int CRED_W = $clog2(`CHART_CREDITS + 1);
	localparam int WAIT_W = $clog2(`SRAM_WAIT + 1);

	fetch_state_e            state;
	logic [`SRAM_ADDR_W-1:0] addr_q;
	logic [CRED_W-1:0]       credits;
	logic [WAIT_W-1:0]       wait_cnt;
	chart_word_t             word_q;
	chart_word_t             dq_word;
	logic                    latch;
	logic                    send;

	// Raw SRAM bus viewed as a chart word
	assign dq_word = chart_word_t'(sram_dq);
	// Last wait cycle, data is stable
	assign latch = (state == FETCH_WAIT) && (wait_cnt == '0);
	// One word out per cycle of credit
	assign send = (state == FETCH_SEND) && (credits != '0);

	// ========================================
	// SRAM side
	// ========================================

	assign sram_addr = addr_q;
	// Output enable only while a read is in flight
	assign sram_oe_n = !((state == FETCH_ADDR) || (state == FETCH_WAIT));

	// Read sequencer
	always_ff @(posedge Clk) begin
		if (reset) begin
			state    <= FETCH_IDLE;
			addr_q   <= '0;
			wait_cnt <= '0;
		end else begin
			case (state)
				FETCH_IDLE: state <= FETCH_ADDR;
				FETCH_ADDR: begin
					// Address is out, start the fixed wait
					wait_cnt <= WAIT_W'(`SRAM_WAIT - 1);
					state    <= FETCH_WAIT;
				end
				FETCH_WAIT: begin
					if (wait_cnt == '0) begin
						// END is never forwarded
						state <= (dq_word.op == CHART_END) ? FETCH_DONE : FETCH_SEND;
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				FETCH_SEND: begin
					// Hold here until the buffer frees a slot
					if (send) begin
						addr_q <= addr_q + 1'b1;
						state  <= FETCH_ADDR;
					end
				end
				default: state <= FETCH_DONE;
			endcase
		end
	end

	// Word capture at the end of the wait
	always_ff @(posedge Clk) begin
		if (latch)
			word_q <= dq_word;
	end

	// ========================================
	// Credit side
	// ========================================

	always_ff @(posedge Clk) begin
		if (reset)
			credits <= CRED_W'(`CHART_CREDITS);
		else
			credits <= credits - CRED_W'(send) + CRED_W'(chart.credit);
	end

	assign chart.valid = send;
	assign chart.op    = word_q.op;
	assign chart.lanes = word_q.lanes;

endmodule

// ==== common/chart_if.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

// Chart word link from the SRAM reader to the lane field
// Sender spends one credit per valid cycle
// Receiver pulses credit once per word it pops
interface chart_if
	import rhythm_pkg::*;
();

	logic              valid;
	chart_op_e         op;
	logic [`LANES-1:0] lanes;
	logic              credit;

	// Reader side
	modport source (
		output valid, op, lanes,
		input  credit
	);

	// Buffer side
	modport sink (
		input  valid, op, lanes,
		output credit
	);

endinterface

// ==== common/rhythm_config.svh ====
`ifndef RHYTHM_CONFIG_SVH
`define RHYTHM_CONFIG_SVH

// ========================================
// Game geometry
// ========================================

// Playable lanes, one key each
`define LANES 4
// Arrow rows per lane, row 0 is the spawn row
`define FIELD_ROWS 16
// First row of the hit window, window ends at the last row
`define HIT_FIRST 12

// ========================================
// Chart memory and link
// ========================================

`define SRAM_ADDR_W 20
`define SRAM_DATA_W 16
// Wait cycles between address out and data latch
`define SRAM_WAIT 2
// Chart buffer depth, also the sender's starting credits
`define CHART_CREDITS 4

// Score counters
`define SCORE_W 16
`define MISS_W 8

`endif

// ==== common/rhythm_pkg.sv ====
`include "rhythm_config.svh"

package rhythm_pkg;

	// ========================================
	// Chart word layout
	// ========================================

	// Opcode in word bits 15:14
	typedef enum logic [1:0] {
		CHART_NOP  = 2'd0,
		CHART_NOTE = 2'd1,
		CHART_END  = 2'd2
	} chart_op_e;

	// One SRAM word per chart row
	typedef struct packed {
		chart_op_e                          op;
		logic [`SRAM_DATA_W-3-`LANES:0]     unused;
		logic [`LANES-1:0]                  lanes;
	} chart_word_t;

	// Chart reader FSM
	typedef enum logic [2:0] {
		FETCH_IDLE,
		FETCH_ADDR,
		FETCH_WAIT,
		FETCH_SEND,
		FETCH_DONE
	} fetch_state_e;

endpackage

// ==== lane/lane_field.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

module lane_field
	import rhythm_pkg::*;
(
	input  logic              Clk,
	input  logic              reset,
	input  logic              frame_tick,
	chart_if.sink             chart,
	input  logic [`LANES-1:0] key_press,
	output logic [`LANES-1:0] hit,
	output logic [`LANES-1:0] miss
);

	localparam int ROWS  = `FIELD_ROWS;
	localparam int PTR_W = $clog2(`CHART_CREDITS);
	localparam int CNT_W = $clog2(`CHART_CREDITS + 1);

	// ========================================
	// Chart word buffer
	// ========================================

	chart_word_t      buf_mem [`CHART_CREDITS];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] buf_count;
	chart_word_t      head;
	logic             pop;

	// One row consumed per frame, if any is waiting
	assign pop  = frame_tick && (buf_count != '0);
	assign head = buf_mem[rd_ptr];

	// Sender credits guarantee a free slot
	always_ff @(posedge Clk) begin
		if (chart.valid)
			buf_mem[wr_ptr] <= '{op: chart.op, unused: '0, lanes: chart.lanes};
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			wr_ptr       <= '0;
			rd_ptr       <= '0;
			buf_count    <= '0;
			chart.credit <= 1'b0;
		end else begin
			if (chart.valid)
				wr_ptr <= (wr_ptr == PTR_W'(`CHART_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(`CHART_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			buf_count    <= buf_count + CNT_W'(chart.valid) - CNT_W'(pop);
			// Slot freed, give the credit back
			chart.credit <= pop;
		end
	end

	// ========================================
	// Keys and arrow field
	// ========================================

	logic [`LANES-1:0]           key_meta;
	logic [`LANES-1:0]           key_sync;
	logic [`LANES-1:0]           key_prev;
	logic [`LANES-1:0]           rise;
	logic [`LANES-1:0]           spawn;
	logic [`LANES-1:0]           hit_now;
	logic [`LANES-1:0]           lost;
	logic [`LANES-1:0][ROWS-1:0] field_q;
	logic [`LANES-1:0][ROWS-1:0] clr;
	logic [`LANES-1:0][ROWS-1:0] field_hit;
	logic [`LANES-1:0][ROWS-1:0] field_next;

	// Fresh presses only, held keys judge once
	assign rise  = key_sync & ~key_prev;
	// NOP rows pop but place nothing
	assign spawn = (pop && (head.op == CHART_NOTE)) ? head.lanes : '0;

	always_comb begin
		for (int l = 0; l < `LANES; l++) begin
			// Lowest arrow inside the window
			clr[l] = '0;
			for (int r = `HIT_FIRST; r < ROWS; r++) begin
				if (field_q[l][r]) begin
					clr[l]    = '0;
					clr[l][r] = 1'b1;
				end
			end
			hit_now[l]   = rise[l] && (clr[l] != '0);
			// Hit removes before the frame shift
			field_hit[l] = hit_now[l] ? (field_q[l] & ~clr[l]) : field_q[l];
			lost[l]      = frame_tick && field_hit[l][ROWS-1];
			if (frame_tick)
				field_next[l] = {field_hit[l][ROWS-2:0], spawn[l]};
			else
				field_next[l] = field_hit[l];
		end
	end

	always_ff @(posedge Clk) begin
		if (reset) begin
			key_meta <= '0;
			key_sync <= '0;
			key_prev <= '0;
			field_q  <= '0;
			hit      <= '0;
			miss     <= '0;
		end else begin
			key_meta <= key_press;
			key_sync <= key_meta;
			key_prev <= key_sync;
			field_q  <= field_next;
			// Both masks are one-cycle pulses
			hit      <= hit_now;
			miss     <= lost;
		end
	end

endmodule

// ==== list.f ====
+incdir+common
common/rhythm_pkg.sv
common/chart_if.sv
chart/chart_fetch.sv
lane/lane_field.sv
rtl/score_keeper.sv
rtl/hex_display.sv
rtl/rhythm_core.sv
verification/rhythm_asserts.sv
verification/rhythm_checker.sv
verification/tb_rhythm.sv

// ==== rtl/hex_display.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

module hex_display (
	input  logic [`SCORE_W-1:0] score,
	output logic [6:0]          hex0,
	output logic [6:0]          hex1,
	output logic [6:0]          hex2,
	output logic [6:0]          hex3
);

	// Active low, bit 0 is segment a, bit 6 is segment g
	function automatic logic [6:0] seg7(input logic [3:0] v);
		case (v)
			4'h0: return 7'h40;
			4'h1: return 7'h79;
			4'h2: return 7'h24;
			4'h3: return 7'h30;
			4'h4: return 7'h19;
			4'h5: return 7'h12;
			4'h6: return 7'h02;
			4'h7: return 7'h78;
			4'h8: return 7'h00;
			4'h9: return 7'h10;
			4'hA: return 7'h08;
			4'hB: return 7'h03;
			4'hC: return 7'h46;
			4'hD: return 7'h21;
			4'hE: return 7'h06;
			default: return 7'h0E;
		endcase
	endfunction

	// Lowest nibble on hex0
	assign hex0 = seg7(score[3:0]);
	assign hex1 = seg7(score[7:4]);
	assign hex2 = seg7(score[11:8]);
	assign hex3 = seg7(score[15:12]);

endmodule

// ==== rtl/rhythm_core.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

module rhythm_core (
	input  logic                    Clk,
	input  logic                    reset,
	input  logic                    frame_tick,
	output logic [`SRAM_ADDR_W-1:0] sram_addr,
	output logic                    sram_oe_n,
	input  logic [`SRAM_DATA_W-1:0] sram_dq,
	input  logic [`LANES-1:0]       key_press,
	output logic [`SCORE_W-1:0]     score,
	output logic [`MISS_W-1:0]      miss_count,
	output logic [6:0]              hex0,
	output logic [6:0]              hex1,
	output logic [6:0]              hex2,
	output logic [6:0]              hex3
);

	// Judge pulses into the score stage
	logic [`LANES-1:0] hit;
	logic [`LANES-1:0] miss;

	// Credit link between reader and field
	chart_if chart_link ();

	// ========================================
	// Stages
	// ========================================

	chart_fetch fetch0 (
		.Clk       (Clk),
		.reset     (reset),
		.chart     (chart_link.source),
		.sram_addr (sram_addr),
		.sram_oe_n (sram_oe_n),
		.sram_dq   (sram_dq)
	);

	lane_field field0 (
		.Clk        (Clk),
		.reset      (reset),
		.frame_tick (frame_tick),
		.chart      (chart_link.sink),
		.key_press  (key_press),
		.hit        (hit),
		.miss       (miss)
	);

	score_keeper keeper0 (
		.Clk        (Clk),
		.reset      (reset),
		.hit        (hit),
		.miss       (miss),
		.score      (score),
		.miss_count (miss_count)
	);

	// Score readout
	hex_display display0 (
		.score (score),
		.hex0  (hex0),
		.hex1  (hex1),
		.hex2  (hex2),
		.hex3  (hex3)
	);

endmodule

// ==== rtl/score_keeper.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

module score_keeper (
	input  logic               Clk,
	input  logic               reset,
	input  logic [`LANES-1:0]  hit,
	input  logic [`LANES-1:0]  miss,
	output logic [`SCORE_W-1:0] score,
	output logic [`MISS_W-1:0]  miss_count
);

	localparam int CNT_W   = $clog2(`LANES + 1);
	localparam int SCORE_X = `SCORE_W + 1;
	localparam int MISS_X  = `MISS_W + 1;

	// Set bits in a lane mask
	function automatic logic [CNT_W-1:0] ones(input logic [`LANES-1:0] mask);
		logic [CNT_W-1:0] n;
		n = '0;
		for (int i = 0; i < `LANES; i++)
			n = n + CNT_W'(mask[i]);
		return n;
	endfunction

	logic [`SCORE_W:0] score_sum;
	logic [`MISS_W:0]  miss_sum;

	// One extra bit catches overflow
	assign score_sum = {1'b0, score} + SCORE_X'(ones(hit));
	assign miss_sum  = {1'b0, miss_count} + MISS_X'(ones(miss));

	always_ff @(posedge Clk) begin
		if (reset) begin
			score      <= '0;
			miss_count <= '0;
		end else begin
			// Saturate at all ones
			score      <= score_sum[`SCORE_W] ? '1 : score_sum[`SCORE_W-1:0];
			miss_count <= miss_sum[`MISS_W] ? '1 : miss_sum[`MISS_W-1:0];
		end
	end

endmodule

// ==== verification/rhythm_asserts.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

module rhythm_asserts #(
	parameter int CRED_W = $clog2(`CHART_CREDITS + 1),
	// Reader instance only sees its credit counter
	parameter bit READER = 1'b0
) (
	input logic              Clk,
	input logic              reset,
	input logic              valid,
	input logic [CRED_W-1:0] credits,
	input logic [`LANES-1:0] hit,
	input logic [`LANES-1:0] miss
);

	// Failures seen, read back by the testbench at the end
	int fail_count = 0;

	// Credits never above buffer depth
	a_credit_max: assert property (@(posedge Clk) disable iff (reset)
		credits <= CRED_W'(`CHART_CREDITS))
	else begin
		$error("credit count %0d above buffer depth", credits);
		fail_count++;
	end

	generate
		if (!READER) begin : g_field
			// No word arrives without a free slot
			a_valid_credit: assert property (@(posedge Clk) disable iff (reset)
				valid |-> (credits != '0))
			else begin
				$error("valid raised with zero credits");
				fail_count++;
			end

			// A lane is judged once per cycle
			a_hit_miss: assert property (@(posedge Clk) disable iff (reset)
				(hit & miss) == '0)
			else begin
				$error("hit and miss set together, hit %b miss %b", hit, miss);
				fail_count++;
			end
		end
	endgenerate

endmodule

// Reader side, credit counter only
bind chart_fetch rhythm_asserts #(.READER(1'b1)) fetch_chk (
	.Clk     (Clk),
	.reset   (reset),
	.valid   (send),
	.credits (credits),
	.hit     ('0),
	.miss    ('0)
);

// Field side, free buffer slots as seen by the receiver
bind lane_field rhythm_asserts field_chk (
	.Clk     (Clk),
	.reset   (reset),
	.valid   (chart.valid),
	.credits (CNT_W'(`CHART_CREDITS) - buf_count),
	.hit     (hit),
	.miss    (miss)
);

// ==== verification/rhythm_checker.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

module rhythm_checker (
	input logic                    Clk,
	input logic                    reset,
	input logic                    frame_tick,
	input logic [`LANES-1:0]       key_press,
	input logic [`SRAM_ADDR_W-1:0] sram_addr,
	input logic                    sram_oe_n,
	input logic [`SCORE_W-1:0]     score,
	input logic [`MISS_W-1:0]      miss_count,
	input logic [6:0]              hex0,
	input logic [6:0]              hex1,
	input logic [6:0]              hex2,
	input logic [6:0]              hex3
);

	// Lit segments per digit, a in bit 0
	localparam logic [6:0] LIT [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D,
		7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

	logic [15:0]             chart_q [$];
	logic [`FIELD_ROWS-1:0]  fld [`LANES];
	logic [`LANES-1:0]       k1, k2, kp, rise;
	int                      pop_idx, exp_score, exp_miss, end_addr;
	bit                      ended, in_test, test_bad, addr_flagged;
	int                      err_count = 0, tests_run = 0, tests_ok = 0;

	function automatic logic [6:0] glyph(input logic [3:0] n);
		return ~LIT[n];
	endfunction

	task automatic report_value(input string sig, input int got, input int exp);
		$display("FAIL t=%0t %s got %0h expected %0h", $time, sig, got, exp);
		test_bad = 1;
		err_count++;
	endtask

	// ========================================
	// Test control from the testbench
	// ========================================

	task automatic clear_chart();
		chart_q.delete();
		ended    = 0;
		end_addr = 0;
	endtask

	// Words after END are never read
	task automatic push_word(input logic [15:0] w);
		if (!ended) begin
			if (w[15:14] == 2'd2)
				ended = 1;
			else begin
				chart_q.push_back(w);
				end_addr++;
			end
		end
	endtask

	task automatic check_outputs();
		if (score != exp_score) report_value("score", score, exp_score);
		if (miss_count != exp_miss) report_value("miss_count", miss_count, exp_miss);
		if (hex0 != glyph(exp_score[3:0])) report_value("hex0", hex0, glyph(exp_score[3:0]));
		if (hex1 != glyph(exp_score[7:4])) report_value("hex1", hex1, glyph(exp_score[7:4]));
		if (hex2 != glyph(exp_score[11:8]))
			report_value("hex2", hex2, glyph(exp_score[11:8]));
		if (hex3 != glyph(exp_score[15:12]))
			report_value("hex3", hex3, glyph(exp_score[15:12]));
	endtask

	// Right after reset everything reads zero
	task automatic begin_test();
		test_bad     = 0;
		addr_flagged = 0;
		in_test      = 1;
		check_outputs();
	endtask

	task automatic end_test(input string name);
		in_test = 0;
		check_outputs();
		if (sram_oe_n !== 1'b1) report_value("sram_oe_n", sram_oe_n, 1);
		if (sram_addr != end_addr) report_value("sram_addr", sram_addr, end_addr);
		tests_run++;
		if (test_bad)
			$display("test %s failed, score %0d misses %0d", name, score, miss_count);
		else begin
			tests_ok++;
			$display("test %s passed, score %0d misses %0d", name, score, miss_count);
		end
	endtask

	task automatic print_totals();
		$display("Tests run %0d, passed %0d, failed %0d", tests_run, tests_ok,
			tests_run - tests_ok);
	endtask

	// ========================================
	// Cycle model of the field
	// ========================================

	always @(posedge Clk) begin
		if (reset) begin
			k1 = '0;
			k2 = '0;
			kp = '0;
			pop_idx   = 0;
			exp_score = 0;
			exp_miss  = 0;
			for (int l = 0; l < `LANES; l++)
				fld[l] = '0;
		end else begin
			rise = k2 & ~kp;
			// Judge first, lowest arrow in the window
			for (int l = 0; l < `LANES; l++) begin
				if (rise[l]) begin
					for (int r = `FIELD_ROWS - 1; r >= `HIT_FIRST; r--) begin
						if (fld[l][r]) begin
							fld[l][r] = 1'b0;
							exp_score++;
							break;
						end
					end
				end
			end
			// Then the frame shift and spawn
			if (frame_tick) begin
				for (int l = 0; l < `LANES; l++) begin
					if (fld[l][`FIELD_ROWS-1])
						exp_miss++;
					fld[l] = fld[l] << 1;
				end
				if (pop_idx < chart_q.size()) begin
					if (chart_q[pop_idx][15:14] == 2'd1)
						for (int l = 0; l < `LANES; l++)
							fld[l][0] = chart_q[pop_idx][l];
					pop_idx++;
				end
			end
			kp = k2;
			k2 = k1;
			k1 = key_press;
			// Reader must stop at the END word
			if (in_test && !addr_flagged && sram_addr > end_addr) begin
				$display("FAIL t=%0t SRAM address ran past the END word", $time);
				addr_flagged = 1;
				test_bad = 1;
				err_count++;
			end
		end
	end

endmodule

// ==== verification/tb_rhythm.sv ====
`timescale 1ns/1ps
`include "rhythm_config.svh"

module tb_rhythm;

	localparam int          N_ROWS  = 67;
	localparam int          N_TESTS = 6;
	localparam logic [15:0] NOP     = 16'h0000;
	localparam logic [15:0] NOTE    = 16'h4000;
	localparam logic [15:0] ENDW    = 16'h8000;

	logic                    Clk = 0;
	logic                    reset;
	logic                    frame_tick;
	logic [`LANES-1:0]       key_press;
	logic [`SRAM_ADDR_W-1:0] sram_addr;
	logic                    sram_oe_n;
	logic [`SRAM_DATA_W-1:0] sram_dq;
	logic [`SCORE_W-1:0]     score;
	logic [`MISS_W-1:0]      miss_count;
	logic [6:0]              hex0, hex1, hex2, hex3;

	// Stimulus table, one row per frame
	logic [15:0] tab_word [N_ROWS];
	logic [3:0]  tab_key [N_ROWS];
	bit          tab_hold [N_ROWS];
	bit          tab_rnd [N_ROWS];
	string       test_name [N_TESTS] = '{"reset_idle", "all_miss", "timed_hits",
		"early_and_hold", "nop_end", "random_keys"};
	int          test_first [N_TESTS] = '{0, 1, 6, 21, 36, 43};
	int          test_len [N_TESTS] = '{1, 5, 15, 15, 7, 24};
	int          cur_first = 0, cur_len = 0;
	integer      seed = 32'h74d7_7aaa;

	always #4 Clk = ~Clk;

	// Chart SRAM, read only, END beyond the slice
	always_comb begin
		if (sram_oe_n)
			sram_dq = '0;
		else if (sram_addr < cur_len)
			sram_dq = tab_word[cur_first + int'(sram_addr)];
		else
			sram_dq = ENDW;
	end

	rhythm_core dut0 (.*);

	rhythm_checker chk0 (.*);

	task automatic build_table();
		for (int i = 0; i < N_ROWS; i++) begin
			tab_word[i] = NOP;
			tab_key[i]  = '0;
			tab_hold[i] = 0;
			tab_rnd[i]  = 0;
		end
		tab_word[0] = ENDW;
		// Unpressed notes
		tab_word[1] = NOTE | 16'h1;
		tab_word[2] = NOTE | 16'hA;
		tab_word[3] = NOTE | 16'hF;
		tab_word[5] = ENDW;
		// Arrows in row 13 when pressed
		tab_word[6] = NOTE | 16'h1;
		tab_word[7] = NOTE | 16'h6;
		tab_key[19] = 4'h1;
		tab_key[20] = 4'h6;
		tab_word[20] = ENDW;
		// Early press, then a held key over two arrows
		tab_word[21] = NOTE | 16'h1;
		tab_word[22] = NOTE | 16'h1;
		tab_key[26] = 4'h1;
		tab_key[34] = 4'h1;
		tab_hold[34] = 1;
		tab_key[35] = 4'h1;
		tab_word[35] = ENDW;
		// Notes stored past END must never spawn
		tab_word[38] = NOTE | 16'h8;
		tab_word[40] = ENDW;
		tab_word[41] = NOTE | 16'hF;
		tab_word[42] = NOTE | 16'hF;
		for (int i = 43; i < N_ROWS; i++) begin
			tab_word[i] = NOTE | 16'((i * 7 + 5) & 15);
			tab_rnd[i]  = 1;
		end
		tab_word[N_ROWS - 1] = ENDW;
	endtask

	// One frame, tick on cycle 0, keys from cycle 16
	task automatic run_frame(input int row, input bit live);
		logic [3:0] mask;
		bit         hold;
		mask = live ? tab_key[row] : 4'h0;
		hold = live ? tab_hold[row] : 1'b0;
		if (live && tab_rnd[row])
			mask = 4'($random(seed));
		for (int c = 0; c < 32; c++) begin
			@(posedge Clk);
			#1;
			frame_tick = (c == 0);
			if (c == 16)
				key_press = mask;
			if (c == 20 && !hold)
				key_press = '0;
		end
	endtask

	// Watchdog from the total frame count
	initial begin
		int limit;
		limit = 1000;
		for (int t = 0; t < N_TESTS; t++)
			limit += 10 + 32 + (test_len[t] + 20) * 32;
		repeat (limit) @(posedge Clk);
		$display("Watchdog expired before all tests finished");
		$display("Simulation failed");
		$finish;
	end

	initial begin
		int asrt_fails;
		reset      = 1;
		frame_tick = 0;
		key_press  = '0;
		build_table();
		for (int t = 0; t < N_TESTS; t++) begin
			cur_first = test_first[t];
			cur_len   = test_len[t];
			chk0.clear_chart();
			for (int i = 0; i < cur_len; i++)
				chk0.push_word(tab_word[cur_first + i]);
			@(posedge Clk);
			#1 reset = 1;
			repeat (10) @(posedge Clk);
			#1 reset = 0;
			#1 chk0.begin_test();
			// Let the reader fill the buffer
			repeat (32) @(posedge Clk);
			for (int f = 0; f < cur_len + 20; f++)
				run_frame(cur_first + f, f < cur_len);
			chk0.end_test(test_name[t]);
		end
		asrt_fails = dut0.fetch0.fetch_chk.fail_count + dut0.field0.field_chk.fail_count;
		if (asrt_fails != 0)
			$display("%0d assertion failures", asrt_fails);
		chk0.print_totals();
		if (chk0.err_count == 0 && asrt_fails == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
